//--- periph_top.f
design/periph_pkg.sv
design/byte_bus_if.sv
design/addr_decoder.sv
design/byte_slot.sv
design/gpio_ctrl.sv
design/read_response.sv
design/periph_top.sv
sim/tb_clock.sv
sim/periph_top_assert.sv
sim/periph_top_tb.sv

//--- Makefile
SIM = obj_dir/sim_periph

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f periph_top.f \
		--top-module periph_top_tb -Mdir obj_dir -o sim_periph

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "Done: no errors" sim.log || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- sim/periph_top_tb.sv
`timescale 1ns/100ps

module periph_top_tb;

    localparam int OP_WRITE = 0;
    localparam int OP_READ  = 1;
    localparam int OP_PINS  = 2;
    localparam int OP_UI    = 3;
    localparam int MAX_ENTRIES = 320;

    logic                  clk;
    logic                  rst_n;
    periph_pkg::addr_t     i_addr;
    periph_pkg::bus_word_t i_wdata;
    logic                  i_write;
    logic                  i_read;
    logic                  i_read_complete;
    periph_pkg::pins_t     i_ui_in;
    periph_pkg::bus_word_t o_rdata;
    logic                  o_ready;
    periph_pkg::pins_t     o_uo_out;

    // Stimulus table
    string                 tab_name [MAX_ENTRIES];
    int                    tab_op   [MAX_ENTRIES];
    periph_pkg::addr_t     tab_addr [MAX_ENTRIES];
    periph_pkg::bus_word_t tab_data [MAX_ENTRIES];
    periph_pkg::bus_word_t tab_exp  [MAX_ENTRIES];
    int                    entry_count;

    // Reference state built from the register map
    periph_pkg::byte_t slot_model [periph_pkg::SLOT_COUNT][periph_pkg::SLOT_REGS];
    periph_pkg::byte_t gpio_model;
    periph_pkg::fsel_t fsel_model [periph_pkg::PIN_COUNT];
    periph_pkg::pins_t ui_model;

    logic [15:0] lfsr_state;
    int          error_count;
    int          test_count;
    int          cycle_count;
    int          cycle_limit;

    tb_clock u_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    periph_top i_periph_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (i_addr),
        .i_wdata         (i_wdata),
        .i_write         (i_write),
        .i_read          (i_read),
        .i_read_complete (i_read_complete),
        .i_ui_in         (i_ui_in),
        .o_rdata         (o_rdata),
        .o_ready         (o_ready),
        .o_uo_out        (o_uo_out)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic periph_pkg::bus_word_t random_bits(input int n);
        periph_pkg::bus_word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic periph_pkg::addr_t gpio_addr(input int ofs);
        return periph_pkg::addr_t'((periph_pkg::PAGE_GPIO << 6) | ofs);
    endfunction

    function automatic periph_pkg::addr_t slot_addr(input int slot, input int ofs);
        return periph_pkg::addr_t'((1 << 10) | (slot << 4) | ofs);
    endfunction

    // Pin p follows the source named by its function select
    function automatic periph_pkg::pins_t expected_pins();
        periph_pkg::pins_t pins;
        periph_pkg::fsel_t f;
        pins = '0;
        for (int p = 0; p < periph_pkg::PIN_COUNT; p++) begin
            f = fsel_model[p];
            if (f[4]) begin
                pins[p] = slot_model[f[3:0]][0][p];
            end else if (f[3:0] == 4'(periph_pkg::PAGE_GPIO)) begin
                pins[p] = gpio_model[p];
            end
        end
        return pins;
    endfunction

    task automatic add_entry(input string name, input int op, input periph_pkg::addr_t addr,
                             input periph_pkg::bus_word_t data,
                             input periph_pkg::bus_word_t exp);
        tab_name[entry_count] = name;
        tab_op[entry_count]   = op;
        tab_addr[entry_count] = addr;
        tab_data[entry_count] = data;
        tab_exp[entry_count]  = exp;
        entry_count++;
    endtask

    task automatic add_slot_write(input int slot, input int ofs, input periph_pkg::byte_t value);
        slot_model[slot][ofs] = value;
        add_entry($sformatf("write slot %0d reg %0d", slot, ofs), OP_WRITE,
                  slot_addr(slot, ofs), 32'(value), '0);
    endtask

    task automatic add_fsel_write(input int pin, input periph_pkg::fsel_t value);
        fsel_model[pin] = value;
        add_entry($sformatf("write fsel %0d", pin), OP_WRITE,
                  gpio_addr(periph_pkg::GPIO_FSEL_BASE + 4 * pin), 32'(value), '0);
    endtask

    task automatic add_pins_check(input string name);
        add_entry(name, OP_PINS, '0, '0, 32'(expected_pins()));
    endtask

    task automatic build_table();
        periph_pkg::byte_t value;
        int                k;
        entry_count = 0;
        for (int p = 0; p < periph_pkg::PIN_COUNT; p++) begin
            fsel_model[p] = periph_pkg::FSEL_RESET;
        end
        gpio_model = '0;
        ui_model   = '0;
        for (int s = 0; s < periph_pkg::SLOT_COUNT; s++) begin
            for (int r = 0; r < periph_pkg::SLOT_REGS; r++) begin
                slot_model[s][r] = '0;
            end
        end

        // Reset state
        add_pins_check("reset pins");
        for (int p = 0; p < periph_pkg::PIN_COUNT; p++) begin
            add_entry($sformatf("reset fsel %0d", p), OP_READ,
                      gpio_addr(periph_pkg::GPIO_FSEL_BASE + 4 * p), '0,
                      32'(periph_pkg::FSEL_RESET));
        end

        // GPIO output, input and unused offsets
        for (int i = 0; i < 4; i++) begin
            value = periph_pkg::byte_t'(random_bits(8));
            gpio_model = value;
            add_entry($sformatf("gpio out write %0d", i), OP_WRITE,
                      gpio_addr(periph_pkg::GPIO_OUT_OFS), 32'(value), '0);
            add_entry($sformatf("gpio out read %0d", i), OP_READ,
                      gpio_addr(periph_pkg::GPIO_OUT_OFS), '0, 32'(value));
            add_pins_check($sformatf("gpio out pins %0d", i));
        end
        ui_model = periph_pkg::pins_t'(random_bits(8));
        add_entry("set ui_in", OP_UI, '0, 32'(ui_model), '0);
        add_entry("gpio in read", OP_READ, gpio_addr(periph_pkg::GPIO_IN_OFS), '0,
                  32'(ui_model));
        add_entry("gpio unused read", OP_READ, gpio_addr(8), '0, '0);
        add_entry("other page read", OP_READ, periph_pkg::addr_t'(2 << 6), '0, '0);

        // Fill every slot, then read all of it back
        for (int s = 0; s < periph_pkg::SLOT_COUNT; s++) begin
            for (int r = 0; r < periph_pkg::SLOT_REGS; r++) begin
                add_slot_write(s, r, periph_pkg::byte_t'(random_bits(8)));
            end
        end
        for (int s = 0; s < periph_pkg::SLOT_COUNT; s++) begin
            for (int r = 0; r < periph_pkg::SLOT_REGS; r++) begin
                add_entry($sformatf("read slot %0d reg %0d", s, r), OP_READ,
                          slot_addr(s, r), '0, 32'(slot_model[s][r]));
            end
            k = 4 + int'(random_bits(3));
            add_entry($sformatf("read slot %0d unmapped %0d", s, k), OP_READ,
                      slot_addr(s, k), '0, '0);
        end
        add_entry("read slot 0 unmapped 15", OP_READ, slot_addr(0, 15), '0, '0);

        // Route each pin to a slot register 0
        for (int p = 0; p < periph_pkg::PIN_COUNT; p++) begin
            k = int'(random_bits(4));
            add_fsel_write(p, periph_pkg::fsel_t'(16 + k));
            add_slot_write(k, 0, periph_pkg::byte_t'(random_bits(8)));
            add_pins_check($sformatf("pin %0d from slot %0d", p, k));
        end

        // Pin 0 source driven high so that forcing it low is visible
        add_slot_write(int'(fsel_model[0][3:0]), 0, 8'hFF);
        add_pins_check("pin 0 source high");
        add_fsel_write(0, '0);
        add_pins_check("pin 0 forced low");
    endtask

    task automatic check_word(input string name, input periph_pkg::bus_word_t exp,
                              input periph_pkg::bus_word_t act);
        test_count++;
        if (exp !== act) begin
            error_count++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end else begin
            $display("[PASS] %s", name);
        end
    endtask

    task automatic check_pins(input string name, input periph_pkg::pins_t exp,
                              input periph_pkg::pins_t act);
        test_count++;
        if (exp !== act) begin
            error_count++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end else begin
            $display("[PASS] %s", name);
        end
    endtask

    // Starts and ends 10 ns after a rising edge
    task automatic bus_write(input string name, input periph_pkg::addr_t addr,
                             input periph_pkg::bus_word_t data);
        i_addr  = addr;
        i_wdata = data;
        i_write = 1'b1;
        #1;
        if (o_ready !== 1'b1) begin
            error_count++;
            $display("Write %s was not acknowledged with o_ready", name);
        end
        @(posedge clk);
        #10 i_write = 1'b0;
    endtask

    task automatic bus_read_start(input periph_pkg::addr_t addr);
        i_addr = addr;
        i_read = 1'b1;
        @(posedge clk);
        #1;
        while (o_ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        #9;
    endtask

    task automatic bus_read_finish();
        i_read          = 1'b0;
        i_read_complete = 1'b1;
        @(posedge clk);
        #10 i_read_complete = 1'b0;
    endtask

    // Response must hold while the core delays read complete
    task automatic read_hold_test();
        periph_pkg::pins_t first;
        periph_pkg::pins_t second;
        first   = periph_pkg::pins_t'(random_bits(8));
        second  = ~first;
        i_ui_in = first;
        bus_read_start(gpio_addr(periph_pkg::GPIO_IN_OFS));
        check_word("hold first capture", 32'(first), o_rdata);
        i_ui_in = second;
        repeat (4) @(posedge clk);
        #10;
        check_word("hold after delay", 32'(first), o_rdata);
        bus_read_finish();
        bus_read_start(gpio_addr(periph_pkg::GPIO_IN_OFS));
        check_word("read after complete", 32'(second), o_rdata);
        bus_read_finish();
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Simulation hung: no progress after %0d cycles", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        i_addr          = '0;
        i_wdata         = '0;
        i_write         = 1'b0;
        i_read          = 1'b0;
        i_read_complete = 1'b0;
        i_ui_in         = '0;
        lfsr_state      = 16'd27;
        error_count     = 0;
        test_count      = 0;
        cycle_count     = 0;
        cycle_limit     = 0;

        build_table();
        // Twenty cycles per entry plus reset, with room for the hold test
        cycle_limit = 20 * (entry_count + 4) + 4;

        wait (rst_n === 1'b1);
        @(posedge clk);
        #10;

        for (int i = 0; i < entry_count; i++) begin
            case (tab_op[i])
                OP_WRITE: bus_write(tab_name[i], tab_addr[i], tab_data[i]);
                OP_READ: begin
                    bus_read_start(tab_addr[i]);
                    check_word(tab_name[i], tab_exp[i], o_rdata);
                    bus_read_finish();
                end
                OP_PINS: check_pins(tab_name[i], periph_pkg::pins_t'(tab_exp[i]), o_uo_out);
                OP_UI: i_ui_in = periph_pkg::pins_t'(tab_data[i]);
                default: ;
            endcase
        end

        read_hold_test();

        // Protocol assertion failures count as errors too
        error_count += i_periph_top.u_periph_top_assert.failures;

        $display("Tests: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sim/periph_top_assert.sv
`timescale 1ns/100ps

module periph_top_assert (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  i_read,
    input logic                  i_write,
    input logic                  i_read_complete,
    input periph_pkg::bus_word_t o_rdata,
    input logic                  o_ready
);

    // Number of assertion failures seen so far
    int failures = 0;

    // Every read is answered one cycle later
    read_ready_next: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_read |=> o_ready
    ) else begin
        $error("o_ready did not follow i_read by one cycle");
        failures++;
    end

    // A held response must not change until the core completes the read
    hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_ready && i_read && !i_read_complete) |=> $stable(o_rdata)
    ) else begin
        $error("o_rdata changed while the read data was held");
        failures++;
    end

    // Writes are acknowledged in the same cycle
    write_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_write |-> o_ready
    ) else begin
        $error("o_ready low during a write");
        failures++;
    end

endmodule

bind periph_top periph_top_assert u_periph_top_assert (.*);

//--- sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held low for four rising edges
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #10 rst_n = 1'b1;
    end

endmodule

//--- design/periph_top.sv
`timescale 1ns/100ps

module periph_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::addr_t     i_addr,
    input  periph_pkg::bus_word_t i_wdata,
    input  logic                  i_write,
    input  logic                  i_read,
    input  logic                  i_read_complete,
    input  periph_pkg::pins_t     i_ui_in,
    output periph_pkg::bus_word_t o_rdata,
    output logic                  o_ready,
    output periph_pkg::pins_t     o_uo_out
);

    byte_bus_if bus ();

    periph_pkg::byte_t slot_rdata [periph_pkg::SLOT_COUNT];
    periph_pkg::pins_t slot_pins  [periph_pkg::SLOT_COUNT];
    periph_pkg::byte_t gpio_rdata;

    addr_decoder u_addr_decoder (
        .i_addr  (i_addr),
        .i_wdata (i_wdata),
        .i_write (i_write),
        .bus     (bus.source)
    );

    // Row of identical byte peripherals in the simple region
    for (genvar s = 0; s < periph_pkg::SLOT_COUNT; s++) begin : g_slot
        byte_slot u_byte_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .bus        (bus.slot),
            .i_write_en (bus.slot_wr[s]),
            .o_rdata    (slot_rdata[s]),
            .o_pins     (slot_pins[s])
        );
    end

    gpio_ctrl u_gpio_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus.gpio),
        .i_ui_in     (i_ui_in),
        .i_slot_pins (slot_pins),
        .o_rdata     (gpio_rdata),
        .o_uo_out    (o_uo_out)
    );

    read_response u_read_response (
        .clk             (clk),
        .rst_n           (rst_n),
        .bus             (bus.response),
        .i_read          (i_read),
        .i_write         (i_write),
        .i_read_complete (i_read_complete),
        .i_slot_rdata    (slot_rdata),
        .i_gpio_rdata    (gpio_rdata),
        .o_rdata         (o_rdata),
        .o_ready         (o_ready)
    );

endmodule

//--- design/read_response.sv
`timescale 1ns/100ps

module read_response (
    input  logic                  clk,
    input  logic                  rst_n,
    byte_bus_if.response          bus,
    input  logic                  i_read,
    input  logic                  i_write,
    input  logic                  i_read_complete,
    input  periph_pkg::byte_t     i_slot_rdata [periph_pkg::SLOT_COUNT],
    input  periph_pkg::byte_t     i_gpio_rdata,
    output periph_pkg::bus_word_t o_rdata,
    output logic                  o_ready
);

    periph_pkg::bus_word_t rdata_mux;
    periph_pkg::bus_word_t rdata_hold;
    logic                  hold;
    logic                  ready_r;
    logic                  capture;

    // Unused user pages fall through to zero
    always_comb begin
        rdata_mux = '0;
        if (bus.sel_simple) begin
            rdata_mux[periph_pkg::BYTE_W-1:0] = i_slot_rdata[bus.slot_idx];
        end else if (bus.sel_gpio) begin
            rdata_mux[periph_pkg::BYTE_W-1:0] = i_gpio_rdata;
        end
    end

    // A full hold register keeps its data until the core completes the read
    assign capture = i_read && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            // Every device answers in one cycle
            ready_r <= i_read;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_hold <= rdata_mux;
        end
    end

    assign o_rdata = rdata_hold;

    // Writes complete in the cycle they are presented
    assign o_ready = ready_r || i_write;

endmodule

//--- design/gpio_ctrl.sv
`timescale 1ns/100ps

module gpio_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    byte_bus_if.gpio          bus,
    input  periph_pkg::pins_t i_ui_in,
    input  periph_pkg::pins_t i_slot_pins [periph_pkg::SLOT_COUNT],
    output periph_pkg::byte_t o_rdata,
    output periph_pkg::pins_t o_uo_out
);

    periph_pkg::byte_t                gpio_out;
    periph_pkg::fsel_t                fsel [periph_pkg::PIN_COUNT];
    logic                             fsel_hit;
    logic [periph_pkg::PIN_IDX_W-1:0] fsel_pin;

    // Selects sit one per word from the base up to the end of the page
    assign fsel_hit = (bus.offset >= periph_pkg::GPIO_FSEL_BASE) && (bus.offset[1:0] == 2'b00);
    assign fsel_pin = bus.offset[2 +: periph_pkg::PIN_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (bus.gpio_wr && (bus.offset == periph_pkg::GPIO_OUT_OFS)) begin
            gpio_out <= bus.wdata;
        end
    end

    always_comb begin
        o_rdata = '0;
        if (bus.offset == periph_pkg::GPIO_OUT_OFS) begin
            o_rdata = gpio_out;
        end else if (bus.offset == periph_pkg::GPIO_IN_OFS) begin
            o_rdata = i_ui_in;
        end else if (fsel_hit) begin
            o_rdata[periph_pkg::FSEL_W-1:0] = fsel[fsel_pin];
        end
    end

    for (genvar p = 0; p < periph_pkg::PIN_COUNT; p++) begin : g_pin
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                fsel[p] <= periph_pkg::FSEL_RESET;
            end else if (bus.gpio_wr && fsel_hit && (fsel_pin == p)) begin
                fsel[p] <= bus.wdata[periph_pkg::FSEL_W-1:0];
            end
        end

        // Top select bit picks a slot, otherwise only the GPIO page drives the pin
        assign o_uo_out[p] =
            fsel[p][periph_pkg::FSEL_W-1] ?
                i_slot_pins[fsel[p][periph_pkg::SLOT_IDX_W-1:0]][p] :
            (fsel[p][periph_pkg::SLOT_IDX_W-1:0] == periph_pkg::PAGE_GPIO) ?
                gpio_out[p] : 1'b0;
    end

endmodule

//--- design/byte_slot.sv
`timescale 1ns/100ps

module byte_slot (
    input  logic              clk,
    input  logic              rst_n,
    byte_bus_if.slot          bus,
    input  logic              i_write_en,
    output periph_pkg::byte_t o_rdata,
    output periph_pkg::pins_t o_pins
);

    periph_pkg::byte_t                   regs [periph_pkg::SLOT_REGS];
    logic                                reg_hit;
    logic [periph_pkg::SLOT_REG_IDX_W-1:0] reg_idx;

    // Offsets past the register file are unmapped
    assign reg_hit = bus.offset < periph_pkg::SLOT_REGS;
    assign reg_idx = bus.offset[periph_pkg::SLOT_REG_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (i_write_en && reg_hit) begin
            regs[reg_idx] <= bus.wdata;
        end
    end

    assign o_rdata = reg_hit ? regs[reg_idx] : '0;

    // Register 0 is the pin vector of this slot
    assign o_pins = regs[0];

endmodule

//--- design/addr_decoder.sv
`timescale 1ns/100ps

module addr_decoder (
    input  periph_pkg::addr_t     i_addr,
    input  periph_pkg::bus_word_t i_wdata,
    input  logic                  i_write,
    byte_bus_if.source            bus
);

    logic                            simple;
    logic [periph_pkg::PAGE_W-1:0]   page;
    periph_pkg::slot_idx_t           slot;

    // Bit 10 splits the simple region from the user pages
    assign simple = i_addr[periph_pkg::SIMPLE_BIT];
    assign page   = i_addr[periph_pkg::PAGE_LSB +: periph_pkg::PAGE_W];
    assign slot   = i_addr[periph_pkg::SLOT_LSB +: periph_pkg::SLOT_IDX_W];

    assign bus.sel_simple = simple;
    assign bus.slot_idx   = slot;
    assign bus.sel_gpio   = !simple && (page == periph_pkg::PAGE_GPIO);

    // Only byte accesses, data on the low lane
    assign bus.wdata = i_wdata[periph_pkg::BYTE_W-1:0];

    // Simple slots only see a 4-bit offset
    always_comb begin
        bus.offset = '0;
        if (simple) begin
            bus.offset[periph_pkg::SLOT_OFS_W-1:0] = i_addr[periph_pkg::SLOT_OFS_W-1:0];
        end else begin
            bus.offset = i_addr[periph_pkg::OFFSET_W-1:0];
        end
    end

    // One-hot write strobe to the addressed slot
    always_comb begin
        bus.slot_wr = '0;
        if (i_write && simple) begin
            bus.slot_wr[slot] = 1'b1;
        end
    end

    assign bus.gpio_wr = i_write && !simple && (page == periph_pkg::PAGE_GPIO);

endmodule

//--- design/byte_bus_if.sv
`timescale 1ns/100ps

interface byte_bus_if;

    logic [periph_pkg::OFFSET_W-1:0]   offset;
    periph_pkg::byte_t                 wdata;
    logic [periph_pkg::SLOT_COUNT-1:0] slot_wr;
    logic                              gpio_wr;

    // Read source selection
    logic                              sel_simple;
    periph_pkg::slot_idx_t             slot_idx;
    logic                              sel_gpio;

    modport source (
        output offset, wdata, slot_wr, gpio_wr, sel_simple, slot_idx, sel_gpio
    );

    modport slot (
        input offset, wdata
    );

    modport gpio (
        input offset, wdata, gpio_wr
    );

    modport response (
        input sel_simple, slot_idx, sel_gpio
    );

endinterface

//--- design/periph_pkg.sv
package periph_pkg;

    // Bus widths
    localparam int ADDR_W    = 11;
    localparam int DATA_W    = 32;
    localparam int BYTE_W    = 8;
    localparam int PIN_COUNT = 8;

    // Simple region slots
    localparam int SLOT_COUNT = 16;
    localparam int SLOT_REGS  = 4;

    // Address fields
    localparam int SIMPLE_BIT = 10;
    localparam int PAGE_LSB   = 6;
    localparam int PAGE_W     = 4;
    localparam int OFFSET_W   = 6;
    localparam int SLOT_LSB   = 4;
    localparam int SLOT_IDX_W = 4;
    localparam int SLOT_OFS_W = 4;

    localparam int PIN_IDX_W      = $clog2(PIN_COUNT);
    localparam int SLOT_REG_IDX_W = $clog2(SLOT_REGS);

    // Function select width, bit 4 picks a slot
    localparam int FSEL_W = 5;

    typedef logic [BYTE_W-1:0]     byte_t;
    typedef logic [PIN_COUNT-1:0]  pins_t;
    typedef logic [FSEL_W-1:0]     fsel_t;
    typedef logic [DATA_W-1:0]     bus_word_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

    // GPIO page and register map
    localparam int PAGE_GPIO      = 1;
    localparam int GPIO_OUT_OFS   = 0;
    localparam int GPIO_IN_OFS    = 4;
    localparam int GPIO_FSEL_BASE = 'h20;

    // All pins come out of reset routed to the GPIO register
    localparam fsel_t FSEL_RESET = fsel_t'(PAGE_GPIO);

endpackage
